// File: wb_fabric.f
common/wb_fabric_pkg.sv
wbs_arbiter/bus_protect.sv
wbs_arbiter/bus_timeout.sv
wbs_arbiter/wbs_arbiter.sv
design/wb_sram.sv
design/wb_slow_regs.sv
design/wb_fabric_top.sv
tb/tb_wb_fabric.sv

// File: tb/tb_wb_fabric.sv
`timescale 1ns/100ps
`default_nettype none

module tb_wb_fabric import wb_fabric_pkg::*; ();

  localparam int unsigned SEED         = 32'h8852827d;
  localparam int          NUM_SRAM_OPS = 48;
  localparam int          XFER_LIMIT   = 100;    // longest legal transfer is the 64 cycle timeout.
  // about 2*48 sram transfers and 30 others, each well under 100 cycles.
  localparam int          MAX_CYCLES   = 20000;
  localparam logic [15:0] REGS_BASE    = 16'h0400;
  localparam logic [15:0] REG_ID_EXP   = 16'hA55A;
  localparam int          REGS_TO_LIM  = 16;

  logic        wb_clk_i = 1'b0;
  logic        wb_rst_i;
  logic        wbm_cyc_i, wbm_stb_i, wbm_we_i;
  logic [15:0] wbm_adr_i, wbm_dat_i;
  logic [1:0]  wbm_id_i;
  wire  [15:0] wbm_dat_o, bm_addr_o;
  wire  [1:0]  bm_wbm_id_o;
  wire         wbm_ack_o, wbm_err_o, bm_memv_o, bm_we_o, bm_timeout_o;

  logic [15:0] sram_model [512];
  logic [8:0]  written_q [$];
  logic [15:0] scratch_a_model, scratch_b_model, delay_model;
  logic        got_ack, got_err, got_memv, got_to;
  logic [15:0] got_dat;
  int          cycle_cnt;
  int unsigned seed_val;

  wb_fabric_top DUT (.*);

  always #20 wb_clk_i = ~wb_clk_i;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else report_failure($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
  endtask

  // one transfer; all outputs are sampled 1 ns after the edge.
  task automatic transfer(input logic [1:0] id, input logic we, input logic [15:0] adr,
                          input logic [15:0] dat);
    int waited;
    waited = 0;
    @(posedge wb_clk_i);
    #1;
    wbm_cyc_i = 1'b1;
    wbm_stb_i = 1'b1;
    wbm_we_i  = we;
    wbm_adr_i = adr;
    wbm_dat_i = dat;
    wbm_id_i  = id;
    do begin
      @(posedge wb_clk_i);
      #1;
      waited++;
      if (waited > XFER_LIMIT) report_failure($sformatf("no ack or err for address %h", adr));
    end while (!wbm_ack_o && !wbm_err_o);
    got_ack   = wbm_ack_o;
    got_err   = wbm_err_o;
    got_memv  = bm_memv_o;
    got_to    = bm_timeout_o;
    got_dat   = wbm_dat_o;
    wbm_cyc_i = 1'b0;  // drop on the cycle the pulse is seen.
    wbm_stb_i = 1'b0;
  endtask

  task automatic expect_ack(input string what);
    assert (got_ack && !got_err) else report_failure({what, " ended in err instead of ack"});
  endtask

  task automatic expect_err(input string what);
    assert (got_err && !got_ack) else report_failure({what, " was acked instead of failing"});
  endtask

  task automatic sram_write(input logic [1:0] id, input logic [8:0] adr, input logic [15:0] dat);
    transfer(id, 1'b1, {7'd0, adr}, dat);
    expect_ack("sram write");
    sram_model[adr] = dat;
    written_q.push_back(adr);
  endtask

  task automatic sram_read_check(input logic [8:0] adr);
    transfer(2'd0, 1'b0, {7'd0, adr}, 16'h0);
    expect_ack("sram read");
    check_equal("wbm_dat_o", got_dat, sram_model[adr]);
  endtask

  // slave ack reaches the master delay+2 cycles after the strobe, a timeout err limit+1.
  function automatic bit regs_ack_wins(input logic [15:0] delay);
    return (delay + 2) <= (REGS_TO_LIM + 1);
  endfunction

  function automatic logic [15:0] regs_expect(input logic [15:0] ofs);
    case (ofs)
      16'd0:   return scratch_a_model;
      16'd1:   return scratch_b_model;
      16'd2:   return delay_model;
      16'd3:   return REG_ID_EXP;
      default: return 16'h0;
    endcase
  endfunction

  // master 0 access to the register window, outcome predicted from the delay model.
  task automatic regs_access(input logic we, input logic [15:0] ofs, input logic [15:0] dat);
    bit ack_exp;
    ack_exp = regs_ack_wins(delay_model);
    transfer(2'd0, we, REGS_BASE + ofs, dat);
    if (ack_exp) begin
      expect_ack("register access");
      if (!we) check_equal("wbm_dat_o", got_dat, regs_expect(ofs));
    end else begin
      expect_err("slow register access");
      check_equal("bm_timeout_o", got_to, 1'b1);
      check_equal("bm_memv_o", got_memv, 1'b0);
      check_equal("bm_addr_o", bm_addr_o, REGS_BASE + ofs);
      check_equal("bm_we_o", bm_we_o, we);
    end
    // registers are written on the strobe, even when the ack comes too late.
    if (we && ofs == 16'd0) scratch_a_model = dat;
    if (we && ofs == 16'd1) scratch_b_model = dat;
    if (we && ofs == 16'd2) delay_model = dat;
  endtask

  task automatic expect_memv(input logic [1:0] id, input logic [15:0] adr, input logic we);
    expect_err("protected access");
    check_equal("bm_memv_o", got_memv, 1'b1);
    check_equal("bm_timeout_o", got_to, 1'b0);
    check_equal("bm_wbm_id_o", bm_wbm_id_o, id);
    check_equal("bm_addr_o", bm_addr_o, adr);
    check_equal("bm_we_o", bm_we_o, we);
  endtask

  // pulse rules, checked on every edge out of reset.
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) !(wbm_ack_o && wbm_err_o))
    else report_failure("ack and err in the same cycle");
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) wbm_ack_o |=> !wbm_ack_o)
    else report_failure("ack lasted more than one cycle");
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) wbm_err_o |=> !wbm_err_o)
    else report_failure("err lasted more than one cycle");
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) bm_memv_o |-> wbm_err_o)
    else report_failure("bm_memv_o pulsed without err");
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) bm_timeout_o |-> wbm_err_o)
    else report_failure("bm_timeout_o pulsed without err");

  always @(posedge wb_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) report_failure("run hung, cycle limit reached");
  end

  initial begin
    logic [15:0] keep;
    wb_rst_i  = 1'b1;
    wbm_cyc_i = 1'b0;
    wbm_stb_i = 1'b0;
    wbm_we_i  = 1'b0;
    wbm_adr_i = 16'h0;
    wbm_dat_i = 16'h0;
    wbm_id_i  = 2'd0;
    cycle_cnt = 0;
    scratch_a_model = 16'h0;
    scratch_b_model = 16'h0;
    delay_model     = 16'h0;
    seed_val = $urandom(SEED);
    repeat (8) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;
    check_equal("wbm_ack_o", wbm_ack_o, 1'b0);
    check_equal("wbm_err_o", wbm_err_o, 1'b0);
    check_equal("bm_memv_o", bm_memv_o, 1'b0);
    check_equal("bm_timeout_o", bm_timeout_o, 1'b0);
    check_equal("state", DUT.u_arbiter.state, ARB_IDLE);

    // sram, both ends of the window and random words in between.
    sram_write(2'd0, 9'h000, 16'($urandom));
    sram_write(2'd0, 9'h1FF, 16'($urandom));
    for (int i = 0; i < NUM_SRAM_OPS; i++) begin
      sram_write(2'd0, 9'($urandom_range(511, 0)), 16'($urandom));
    end
    for (int i = 0; i < NUM_SRAM_OPS; i++) begin
      sram_read_check(written_q[$urandom_range(written_q.size() - 1, 0)]);
    end

    // register block through the rebased window.
    regs_access(1'b1, 16'd0, 16'($urandom));
    regs_access(1'b1, 16'd1, 16'($urandom));
    regs_access(1'b0, 16'd0, 16'h0);
    regs_access(1'b0, 16'd1, 16'h0);
    regs_access(1'b0, 16'd3, 16'h0);
    regs_access(1'b0, 16'h0010, 16'h0);

    // protection faults.
    keep = 16'($urandom);
    sram_write(2'd0, 9'h040, keep);
    transfer(2'd2, 1'b1, 16'h0040, ~keep);
    expect_memv(2'd2, 16'h0040, 1'b1);
    sram_read_check(9'h040);
    transfer(2'd1, 1'b0, 16'h0401, 16'h0);
    expect_memv(2'd1, 16'h0401, 1'b0);
    transfer(2'd1, 1'b1, 16'h0400, ~scratch_a_model);
    expect_memv(2'd1, 16'h0400, 1'b1);
    regs_access(1'b0, 16'd0, 16'h0);
    sram_write(2'd2, 9'h150, 16'($urandom));
    sram_read_check(9'h150);

    // unmapped address; the fault record keeps the last protection fault.
    transfer(2'd0, 1'b0, 16'h0800, 16'h0);
    expect_err("unmapped access");
    check_equal("bm_memv_o", got_memv, 1'b0);
    check_equal("bm_timeout_o", got_to, 1'b0);
    check_equal("bm_addr_o", bm_addr_o, 16'h0400);

    // bus timeout on a slow register block.
    regs_access(1'b1, 16'd2, 16'd40);
    regs_access(1'b0, 16'd0, 16'h0);
    check_equal("bm_wbm_id_o", bm_wbm_id_o, 2'd0);
    regs_access(1'b1, 16'd2, 16'd2);
    regs_access(1'b0, 16'd0, 16'h0);
    regs_access(1'b0, 16'd2, 16'h0);

    repeat (4) @(posedge wb_clk_i);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/wb_fabric_top.sv
`timescale 1ns/100ps
`default_nettype none

module wb_fabric_top import wb_fabric_pkg::*; #(
  parameter int                          NUM_SLAVES  = 2,
  // window 0 is the sram, window 1 the register block.
  parameter logic [NUM_SLAVES*ADR_W-1:0] SLV_BASE    = {16'h0400, 16'h0000},
  parameter logic [NUM_SLAVES*ADR_W-1:0] SLV_HIGH    = {16'h043F, 16'h01FF},
  parameter int                          NUM_RULES   = 2,
  // {mask, deny rd, deny wr, low, high}, rule 0 in the low bits.
  parameter logic [NUM_RULES*RULE_W-1:0] RULES       = {
    {4'b0010, 1'b1, 1'b1, 16'h0400, 16'h043F},
    {4'b1100, 1'b0, 1'b1, 16'h0000, 16'h00FF}
  },
  parameter int                          NUM_TOR     = 1,
  parameter logic [NUM_TOR*TOR_W-1:0]    TO_RULES    = {16'h0400, 16'h043F, 20'd16},
  parameter logic [TO_CNT_W-1:0]         TO_DEFAULT  = 20'd64,
  parameter int                          SRAM_DEPTH  = 512,
  parameter logic [DAT_W-1:0]            REG_ID      = 16'hA55A
) (
  input  wire               wb_clk_i,
  input  wire               wb_rst_i,
  input  wire               wbm_cyc_i,
  input  wire               wbm_stb_i,
  input  wire               wbm_we_i,
  input  wire [ADR_W-1:0]   wbm_adr_i,
  input  wire [DAT_W-1:0]   wbm_dat_i,
  input  wire [MID_W-1:0]   wbm_id_i,
  output logic [DAT_W-1:0]  wbm_dat_o,
  output logic              wbm_ack_o,
  output logic              wbm_err_o,
  output logic              bm_memv_o,
  output logic [MID_W-1:0]  bm_wbm_id_o,
  output logic [ADR_W-1:0]  bm_addr_o,
  output logic              bm_we_o,
  output logic              bm_timeout_o
);

  localparam int SRAM_IDX = 0;
  localparam int REGS_IDX = 1;

  logic [NUM_SLAVES-1:0]        wbs_cyc;
  logic [NUM_SLAVES-1:0]        wbs_stb;
  logic                         wbs_we;
  logic [ADR_W-1:0]             wbs_adr;
  logic [DAT_W-1:0]             wbs_dat_w;
  logic [NUM_SLAVES*DAT_W-1:0]  wbs_dat_r;
  logic [NUM_SLAVES-1:0]        wbs_ack;

  wbs_arbiter #(
    .NUM_SLAVES (NUM_SLAVES),
    .SLV_BASE   (SLV_BASE),
    .SLV_HIGH   (SLV_HIGH),
    .NUM_RULES  (NUM_RULES),
    .RULES      (RULES),
    .NUM_TOR    (NUM_TOR),
    .TO_RULES   (TO_RULES),
    .TO_DEFAULT (TO_DEFAULT)
  ) u_arbiter (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wbm_cyc_i    (wbm_cyc_i),
    .wbm_stb_i    (wbm_stb_i),
    .wbm_we_i     (wbm_we_i),
    .wbm_adr_i    (wbm_adr_i),
    .wbm_dat_i    (wbm_dat_i),
    .wbm_id_i     (wbm_id_i),
    .wbm_dat_o    (wbm_dat_o),
    .wbm_ack_o    (wbm_ack_o),
    .wbm_err_o    (wbm_err_o),
    .wbs_cyc_o    (wbs_cyc),
    .wbs_stb_o    (wbs_stb),
    .wbs_we_o     (wbs_we),
    .wbs_adr_o    (wbs_adr),
    .wbs_dat_o    (wbs_dat_w),
    .wbs_dat_i    (wbs_dat_r),
    .wbs_ack_i    (wbs_ack),
    .bm_memv_o    (bm_memv_o),
    .bm_wbm_id_o  (bm_wbm_id_o),
    .bm_addr_o    (bm_addr_o),
    .bm_we_o      (bm_we_o),
    .bm_timeout_o (bm_timeout_o)
  );

  wb_sram #(
    .DEPTH (SRAM_DEPTH)
  ) u_sram (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .cyc_i    (wbs_cyc[SRAM_IDX]),
    .stb_i    (wbs_stb[SRAM_IDX]),
    .we_i     (wbs_we),
    .adr_i    (wbs_adr[$clog2(SRAM_DEPTH)-1:0]),  // window is exactly the sram size.
    .dat_i    (wbs_dat_w),
    .dat_o    (wbs_dat_r[SRAM_IDX*DAT_W +: DAT_W]),
    .ack_o    (wbs_ack[SRAM_IDX])
  );

  wb_slow_regs #(
    .REG_ID (REG_ID)
  ) u_slow_regs (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .cyc_i    (wbs_cyc[REGS_IDX]),
    .stb_i    (wbs_stb[REGS_IDX]),
    .we_i     (wbs_we),
    .adr_i    (wbs_adr),
    .dat_i    (wbs_dat_w),
    .dat_o    (wbs_dat_r[REGS_IDX*DAT_W +: DAT_W]),
    .ack_o    (wbs_ack[REGS_IDX])
  );

endmodule

`default_nettype wire

// File: design/wb_slow_regs.sv
`timescale 1ns/100ps
`default_nettype none

module wb_slow_regs import wb_fabric_pkg::*; #(
  parameter logic [DAT_W-1:0] REG_ID = '0
) (
  input  wire              wb_clk_i,
  input  wire              wb_rst_i,
  input  wire              cyc_i,
  input  wire              stb_i,
  input  wire              we_i,
  input  wire [ADR_W-1:0]  adr_i,
  input  wire [DAT_W-1:0]  dat_i,
  output logic [DAT_W-1:0] dat_o,
  output logic             ack_o
);

  localparam logic [ADR_W-1:0] OFS_SCRATCH_A = 'd0;
  localparam logic [ADR_W-1:0] OFS_SCRATCH_B = 'd1;
  localparam logic [ADR_W-1:0] OFS_DELAY     = 'd2;
  localparam logic [ADR_W-1:0] OFS_ID        = 'd3;

  logic [DAT_W-1:0] scratch_a;
  logic [DAT_W-1:0] scratch_b;
  logic [DAT_W-1:0] delay_q;
  logic [DAT_W-1:0] wait_cnt;
  logic             busy;
  logic             req;

  assign req = cyc_i && stb_i;

  // the access itself happens on the strobe, only the ack is delayed.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      scratch_a <= '0;
      scratch_b <= '0;
      delay_q   <= '0;
    end else if (req && we_i) begin
      case (adr_i)
        OFS_SCRATCH_A: scratch_a <= dat_i;
        OFS_SCRATCH_B: scratch_b <= dat_i;
        OFS_DELAY:     delay_q   <= dat_i;
        default:       ;  // id and unused offsets ignore writes.
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (req && !we_i) begin
      case (adr_i)
        OFS_SCRATCH_A: dat_o <= scratch_a;
        OFS_SCRATCH_B: dat_o <= scratch_b;
        OFS_DELAY:     dat_o <= delay_q;
        OFS_ID:        dat_o <= REG_ID;
        default:       dat_o <= '0;
      endcase
    end
  end

  // wait states; a new strobe drops whatever was still counting.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      busy     <= 1'b0;
      wait_cnt <= '0;
      ack_o    <= 1'b0;
    end else begin
      ack_o <= 1'b0;
      if (req) begin
        if (delay_q == '0) begin
          ack_o <= 1'b1;
          busy  <= 1'b0;
        end else begin
          busy     <= 1'b1;
          wait_cnt <= delay_q - 1'b1;
        end
      end else if (busy) begin
        if (wait_cnt == '0) begin
          ack_o <= 1'b1;
          busy  <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/wb_sram.sv
`timescale 1ns/100ps
`default_nettype none

module wb_sram import wb_fabric_pkg::*; #(
  parameter int   DEPTH = 512,
  localparam int  AW    = $clog2(DEPTH)
) (
  input  wire              wb_clk_i,
  input  wire              wb_rst_i,
  input  wire              cyc_i,
  input  wire              stb_i,
  input  wire              we_i,
  input  wire [AW-1:0]     adr_i,
  input  wire [DAT_W-1:0]  dat_i,
  output logic [DAT_W-1:0] dat_o,
  output logic             ack_o
);

  logic [DAT_W-1:0] mem [DEPTH];
  logic             req;

  assign req = cyc_i && stb_i;

  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      if (we_i) begin
        mem[adr_i] <= dat_i;
      end else begin
        dat_o <= mem[adr_i];  // held until the next read.
      end
    end
  end

  // strobe is a single pulse, so the ack is too.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= req;
    end
  end

endmodule

`default_nettype wire

// File: wbs_arbiter/wbs_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module wbs_arbiter import wb_fabric_pkg::*; #(
  parameter int                              NUM_SLAVES = 1,
  parameter logic [NUM_SLAVES*ADR_W-1:0]     SLV_BASE   = '0,
  parameter logic [NUM_SLAVES*ADR_W-1:0]     SLV_HIGH   = '0,
  parameter int                              NUM_RULES  = 1,
  parameter logic [NUM_RULES*RULE_W-1:0]     RULES      = '0,
  parameter int                              NUM_TOR    = 1,
  parameter logic [NUM_TOR*TOR_W-1:0]        TO_RULES   = '0,
  parameter logic [TO_CNT_W-1:0]             TO_DEFAULT = '0
) (
  input  wire                          wb_clk_i,
  input  wire                          wb_rst_i,
  // master side.
  input  wire                          wbm_cyc_i,
  input  wire                          wbm_stb_i,
  input  wire                          wbm_we_i,
  input  wire [ADR_W-1:0]              wbm_adr_i,
  input  wire [DAT_W-1:0]              wbm_dat_i,
  input  wire [MID_W-1:0]              wbm_id_i,
  output logic [DAT_W-1:0]             wbm_dat_o,
  output logic                         wbm_ack_o,
  output logic                         wbm_err_o,
  // slave side.
  output logic [NUM_SLAVES-1:0]        wbs_cyc_o,
  output logic [NUM_SLAVES-1:0]        wbs_stb_o,
  output logic                         wbs_we_o,
  output logic [ADR_W-1:0]             wbs_adr_o,
  output logic [DAT_W-1:0]             wbs_dat_o,
  input  wire [NUM_SLAVES*DAT_W-1:0]   wbs_dat_i,
  input  wire [NUM_SLAVES-1:0]         wbs_ack_i,
  // bus monitor.
  output logic                         bm_memv_o,
  output logic [MID_W-1:0]             bm_wbm_id_o,
  output logic [ADR_W-1:0]             bm_addr_o,
  output logic                         bm_we_o,
  output logic                         bm_timeout_o
);

  arb_state_e              state;
  logic [NUM_SLAVES-1:0]   win_hit;
  logic [NUM_SLAVES-1:0]   win_sel;
  logic [ADR_W-1:0]        win_adr;
  logic [NUM_SLAVES-1:0]   active_q;
  logic [DAT_W-1:0]        ack_dat;
  logic                    req;
  logic                    slv_ack;
  logic                    vcheck;
  logic                    vpass;
  logic                    vfail;
  logic                    timeout;
  logic                    fault_q;   // err decided, goes out next cycle.
  logic                    memv_q;    // that err is a protection fault.
  logic                    prot_fault;
  logic                    to_fault;

  bus_protect #(
    .NUM_RULES (NUM_RULES),
    .RULES     (RULES)
  ) u_bus_protect (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .vcheck_i (vcheck),
    .adr_i    (wbm_adr_i),
    .we_i     (wbm_we_i),
    .wbm_id_i (wbm_id_i),
    .vpass_o  (vpass),
    .vfail_o  (vfail)
  );

  bus_timeout #(
    .NUM_TOR    (NUM_TOR),
    .TO_RULES   (TO_RULES),
    .TO_DEFAULT (TO_DEFAULT)
  ) u_bus_timeout (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .clear_i   (state != ARB_WAIT),
    .adr_i     (wbm_adr_i),
    .timeout_o (timeout)
  );

  for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_win
    localparam logic [ADR_W-1:0] BASE = SLV_BASE[s*ADR_W +: ADR_W];
    localparam logic [ADR_W-1:0] HIGH = SLV_HIGH[s*ADR_W +: ADR_W];

    assign win_hit[s] = (wbm_adr_i[ADR_W-1:WIN_ALIGN] >= BASE[ADR_W-1:WIN_ALIGN]) &&
                        (wbm_adr_i[ADR_W-1:WIN_ALIGN] <= HIGH[ADR_W-1:WIN_ALIGN]);
  end

  // lowest window wins an overlap, the loop runs top down.
  always_comb begin
    win_sel = '0;
    win_adr = '0;
    for (int s = NUM_SLAVES - 1; s >= 0; s--) begin
      if (win_hit[s]) begin
        win_sel    = '0;
        win_sel[s] = 1'b1;
        win_adr    = wbm_adr_i - SLV_BASE[s*ADR_W +: ADR_W];
      end
    end
  end

  always_comb begin
    ack_dat = '0;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      if (active_q[s]) ack_dat = wbs_dat_i[s*DAT_W +: DAT_W];
    end
  end

  // ignore the held strobe while our ack or err is still on the bus.
  assign req        = wbm_cyc_i && wbm_stb_i && !wbm_ack_o && !wbm_err_o;
  assign slv_ack    = |(wbs_ack_i & active_q);
  assign prot_fault = (state == ARB_VCHECK) && fault_q && memv_q;
  assign to_fault   = (state == ARB_WAIT) && !slv_ack && timeout;
  assign wbs_stb_o  = wbs_cyc_o;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state        <= ARB_IDLE;
      active_q     <= '0;
      vcheck       <= 1'b0;
      fault_q      <= 1'b0;
      memv_q       <= 1'b0;
      wbs_cyc_o    <= '0;
      wbm_ack_o    <= 1'b0;
      wbm_err_o    <= 1'b0;
      bm_memv_o    <= 1'b0;
      bm_timeout_o <= 1'b0;
    end else begin
      vcheck       <= 1'b0;  // everything below is a single-cycle pulse.
      wbs_cyc_o    <= '0;
      wbm_ack_o    <= 1'b0;
      wbm_err_o    <= 1'b0;
      bm_memv_o    <= 1'b0;
      bm_timeout_o <= 1'b0;
      case (state)
        ARB_IDLE: begin
          if (req) begin
            active_q <= win_sel;
            vcheck   <= 1'b1;
            state    <= ARB_VCHECK;
          end
        end
        ARB_VCHECK: begin
          if (fault_q) begin
            wbm_err_o <= 1'b1;
            bm_memv_o <= memv_q;
            fault_q   <= 1'b0;
            state     <= ARB_IDLE;
          end else if (vfail || (vpass && active_q == '0)) begin
            fault_q <= 1'b1;
            memv_q  <= vfail;  // unmapped without a rule hit is a plain err.
          end else if (vpass) begin
            wbs_cyc_o <= active_q;
            state     <= ARB_WAIT;
          end
        end
        ARB_WAIT: begin
          if (slv_ack) begin
            wbm_ack_o <= 1'b1;
            state     <= ARB_IDLE;
          end else if (to_fault) begin
            wbm_err_o    <= 1'b1;
            bm_timeout_o <= 1'b1;
            state        <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // request payload toward the slaves, and read data back to the master.
  always_ff @(posedge wb_clk_i) begin
    if (state == ARB_IDLE && req) begin
      wbs_adr_o <= win_adr;
      wbs_we_o  <= wbm_we_i;
      wbs_dat_o <= wbm_dat_i;
    end
    if (state == ARB_WAIT && slv_ack) wbm_dat_o <= ack_dat;
  end

  // the master still holds the request here, so copy it straight in.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      bm_wbm_id_o <= '0;
      bm_addr_o   <= '0;
      bm_we_o     <= 1'b0;
    end else if (prot_fault || to_fault) begin
      bm_wbm_id_o <= wbm_id_i;
      bm_addr_o   <= wbm_adr_i;
      bm_we_o     <= wbm_we_i;
    end
  end

endmodule

`default_nettype wire

// File: wbs_arbiter/bus_timeout.sv
`timescale 1ns/100ps
`default_nettype none

module bus_timeout import wb_fabric_pkg::*; #(
  parameter int                        NUM_TOR    = 1,
  parameter logic [NUM_TOR*TOR_W-1:0]  TO_RULES   = '0,
  parameter logic [TO_CNT_W-1:0]       TO_DEFAULT = '0
) (
  input  wire              wb_clk_i,
  input  wire              wb_rst_i,
  input  wire              clear_i,
  input  wire [ADR_W-1:0]  adr_i,
  output logic             timeout_o
);

  logic [NUM_TOR-1:0]  tor_hit;
  logic [TO_CNT_W-1:0] tor_limit [NUM_TOR];
  logic [TO_CNT_W-1:0] limit;
  logic [TO_CNT_W-1:0] count;

  for (genvar i = 0; i < NUM_TOR; i++) begin : g_tor
    localparam logic [TOR_W-1:0] TOR = TO_RULES[i*TOR_W +: TOR_W];

    assign tor_hit[i]   = (adr_i >= TOR[TOR_LOW_LSB +: ADR_W]) &&
                          (adr_i <= TOR[TOR_HIGH_LSB +: ADR_W]);
    assign tor_limit[i] = TOR[TOR_LIMIT_LSB +: TO_CNT_W];
  end

  // walk downwards so the first matching rule is the one that sticks.
  always_comb begin
    limit = TO_DEFAULT;
    for (int i = NUM_TOR - 1; i >= 0; i--) begin
      if (tor_hit[i]) limit = tor_limit[i];
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || clear_i) begin
      count <= '0;
    end else if (count != limit) begin
      count <= count + 1'b1;  // saturates at the limit.
    end
  end

  assign timeout_o = (count == limit);

endmodule

`default_nettype wire

// File: wbs_arbiter/bus_protect.sv
`timescale 1ns/100ps
`default_nettype none

module bus_protect import wb_fabric_pkg::*; #(
  parameter int                          NUM_RULES = 1,
  parameter logic [NUM_RULES*RULE_W-1:0] RULES     = '0
) (
  input  wire              wb_clk_i,
  input  wire              wb_rst_i,
  input  wire              vcheck_i,
  input  wire [ADR_W-1:0]  adr_i,
  input  wire              we_i,
  input  wire [MID_W-1:0]  wbm_id_i,
  output logic             vpass_o,
  output logic             vfail_o
);

  logic [NUM_MASTERS-1:0] mst_onehot;
  logic [NUM_RULES-1:0]   rule_hit;

  always_comb begin
    mst_onehot = '0;
    mst_onehot[wbm_id_i] = 1'b1;
  end

  // one comparator set per rule.
  for (genvar i = 0; i < NUM_RULES; i++) begin : g_rule
    localparam logic [RULE_W-1:0] RULE = RULES[i*RULE_W +: RULE_W];
    localparam logic [ADR_W-1:0]  LOW  = RULE[RULE_LOW_LSB +: ADR_W];
    localparam logic [ADR_W-1:0]  HIGH = RULE[RULE_HIGH_LSB +: ADR_W];

    logic mst_match;
    logic in_range;
    logic denied;

    assign mst_match = |(RULE[RULE_MASK_LSB +: NUM_MASTERS] & mst_onehot);
    assign in_range  = (adr_i >= LOW) && (adr_i <= HIGH);
    assign denied    = we_i ? RULE[RULE_DENY_WR] : RULE[RULE_DENY_RD];
    assign rule_hit[i] = mst_match && in_range && denied;
  end

  // verdict is a single pulse, one cycle behind vcheck.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      vpass_o <= 1'b0;
      vfail_o <= 1'b0;
    end else begin
      vpass_o <= vcheck_i && !(|rule_hit);
      vfail_o <= vcheck_i && (|rule_hit);
    end
  end

endmodule

`default_nettype wire

// File: common/wb_fabric_pkg.sv
`default_nettype none

package wb_fabric_pkg;

  localparam int ADR_W = 16;
  localparam int DAT_W = 16;
  localparam int MID_W = 2;
  localparam int NUM_MASTERS = 1 << MID_W;

  // window compares skip these low bits, so a window spans at least 64 words.
  localparam int WIN_ALIGN = 6;

  // protection rule, msb first: master mask, deny read, deny write, low, high.
  localparam int RULE_HIGH_LSB = 0;
  localparam int RULE_LOW_LSB  = 16;
  localparam int RULE_DENY_WR  = 32;
  localparam int RULE_DENY_RD  = 33;
  localparam int RULE_MASK_LSB = 34;
  localparam int RULE_W        = RULE_MASK_LSB + NUM_MASTERS;

  // timeout rule, msb first: low, high, limit.
  localparam int TO_CNT_W      = 20;
  localparam int TOR_LIMIT_LSB = 0;
  localparam int TOR_HIGH_LSB  = 20;
  localparam int TOR_LOW_LSB   = 36;
  localparam int TOR_W         = TOR_LOW_LSB + ADR_W;

  typedef enum logic [1:0] {
    ARB_IDLE,    // waiting for a master request.
    ARB_VCHECK,  // protection verdict pending.
    ARB_WAIT     // slave strobed, waiting for its ack.
  } arb_state_e;

endpackage

`default_nettype wire
